// ==== Bender.yml ====
package:
  name: qupls_mem_unit

sources:
  # Package first, then the stages, then the top level
  - files:
      - hdl/QuplsMemPkg.sv
      - hdl/QuplsDecodeMem.sv
      - hdl/QuplsAgen.sv
      - hdl/QuplsDataRam.sv
      - hdl/QuplsLoadAlign.sv
      - hdl/QuplsMemUnit.sv

  # Testbench with top module QuplsMemUnitTb
  - target: test
    files:
      - testbench/QuplsMemUnitTb.sv

// ==== QuplsMemUnit.f ====
hdl/QuplsMemPkg.sv
hdl/QuplsDecodeMem.sv
hdl/QuplsAgen.sv
hdl/QuplsDataRam.sv
hdl/QuplsLoadAlign.sv
hdl/QuplsMemUnit.sv
testbench/QuplsMemUnitTb.sv

// ==== hdl/QuplsAgen.sv ====
// Execute stage forming the effective address, alignment check, byte enables and store lanes
`timescale 1ns/1ps

module QuplsAgen import QuplsMemPkg::*;
(
	input logic clk,
	input logic arstN,
	input logic instrValid,
	input logic isMem,
	input memOp_t op,
	input instruction_t instr,
	input logic [DataWidth-1:0] aVal,
	input logic [DataWidth-1:0] bVal,
	input logic [DataWidth-1:0] tVal,
	output memReq_t agenReq
);

	logic [AddrWidth-1:0] dispExt;
	logic [AddrWidth-1:0] offset;
	logic [AddrWidth-1:0] effAddr;
	logic [LaneWidth-1:0] lane;
	logic [BytesPerWord-1:0] sizeMask;
	logic misaligned;
	memReq_t reqNext;
	memReq_t reqQ;
	logic reqValidQ;

	// Displacement is sign extended to address width
	assign dispExt = {{(AddrWidth-DispWidth){instr.disp[DispWidth-1]}}, instr.disp};

	// ==========================================================================
	// Address and lane generation
	// ==========================================================================

	always_comb
	begin
		offset = op.indexed ? bVal[AddrWidth-1:0] : dispExt;
		effAddr = aVal[AddrWidth-1:0] + offset;
		lane = effAddr[LaneWidth-1:0];

		// Low address bits below the access size must be zero
		case (op.size)
			SzByte:
			begin
				sizeMask = 8'h01;
				misaligned = 1'b0;
			end
			SzWyde:
			begin
				sizeMask = 8'h03;
				misaligned = effAddr[0];
			end
			SzTetra:
			begin
				sizeMask = 8'h0F;
				misaligned = |effAddr[1:0];
			end
			default:
			begin
				sizeMask = 8'hFF;
				misaligned = |effAddr[2:0];
			end
		endcase

		reqNext.valid = instrValid & isMem;
		reqNext.isLoad = op.isLoad;
		reqNext.isStore = op.isStore;
		reqNext.fault = misaligned;
		// Bits above 10 are dropped so the memory wraps every 2 KiB
		reqNext.wordAddr = effAddr[RamAddrWidth+LaneWidth-1:LaneWidth];
		reqNext.byteLane = lane;
		// A faulted op enables no bytes at all
		reqNext.byteEn = misaligned ? '0 : sizeMask << lane;
		// Little-endian placement of the store data at its lane
		reqNext.wrData = tVal << {lane, 3'b000};
		reqNext.size = op.size;
		reqNext.signExt = op.signExt;
		reqNext.tag = op.tag;
	end

	// Valid is the only control bit that needs clearing
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			reqValidQ <= 1'b0;
		else
			reqValidQ <= reqNext.valid;
	end

	always_ff @(posedge clk)
	begin
		if (reqNext.valid)
			reqQ <= reqNext;
	end

	always_comb
	begin
		agenReq = reqQ;
		agenReq.valid = reqValidQ;
	end

endmodule

// ==== hdl/QuplsDataRam.sv ====
// Byte-writable synchronous data memory of 256 octas that keeps the request beside its read data
`timescale 1ns/1ps

module QuplsDataRam import QuplsMemPkg::*;
(
	input logic clk,
	input logic arstN,
	input memReq_t agenReq,
	output memReq_t ramReq,
	output logic [DataWidth-1:0] ramData
);

	logic [DataWidth-1:0] mem [RamDepth];
	logic wrEn;
	memReq_t reqQ;
	logic reqValidQ;

	// Only an aligned store may touch the array
	assign wrEn = agenReq.valid & agenReq.isStore & ~agenReq.fault;

	// ==========================================================================
	// Storage
	// ==========================================================================

	always_ff @(posedge clk)
	begin
		for (int b = 0; b < BytesPerWord; b++)
		begin
			if (wrEn && agenReq.byteEn[b])
				mem[agenReq.wordAddr][b*8 +: 8] <= agenReq.wrData[b*8 +: 8];
		end
		// Read sees the old contents when the same octa is written this cycle
		ramData <= mem[agenReq.wordAddr];
	end

	// Request follows the data by one edge so result knows its lane and size
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			reqValidQ <= 1'b0;
		else
			reqValidQ <= agenReq.valid;
	end

	always_ff @(posedge clk)
	begin
		if (agenReq.valid)
			reqQ <= agenReq;
	end

	always_comb
	begin
		ramReq = reqQ;
		ramReq.valid = reqValidQ;
	end

endmodule

// ==== hdl/QuplsDecodeMem.sv ====
// Memory decode that sorts an instruction into load, store or other and gives size and mode
`timescale 1ns/1ps

module QuplsDecodeMem import QuplsMemPkg::*;
(
	input instruction_t instr,
	output memOp_t op,
	output logic isMem
);

	// ==========================================================================
	// Load and store tables
	// ==========================================================================

	always_comb
	begin
		// Everything defaults to a non-memory op with an octa size
		op = '0;
		op.size = SzOcta;
		// The target register doubles as the store data source
		op.tag = instr.rt;

		// Load table, the U suffix drops sign extension
		case (instr.opcode)
			OP_LDB:
			begin
				op.isLoad = 1'b1;
				op.size = SzByte;
				op.signExt = 1'b1;
			end
			OP_LDBU:
			begin
				op.isLoad = 1'b1;
				op.size = SzByte;
			end
			OP_LDW:
			begin
				op.isLoad = 1'b1;
				op.size = SzWyde;
				op.signExt = 1'b1;
			end
			OP_LDWU:
			begin
				op.isLoad = 1'b1;
				op.size = SzWyde;
			end
			OP_LDT:
			begin
				op.isLoad = 1'b1;
				op.size = SzTetra;
				op.signExt = 1'b1;
			end
			OP_LDTU:
			begin
				op.isLoad = 1'b1;
				op.size = SzTetra;
			end
			// Octa loads fill the whole register so extension has no effect
			OP_LDO, OP_LDX:
			begin
				op.isLoad = 1'b1;
				op.size = SzOcta;
				op.signExt = 1'b1;
			end
			default:
			begin
				op.isLoad = 1'b0;
			end
		endcase

		// Store table
		case (instr.opcode)
			OP_STB: op.isStore = 1'b1;
			OP_STW: op.isStore = 1'b1;
			OP_STT: op.isStore = 1'b1;
			OP_STO, OP_STX: op.isStore = 1'b1;
			default: op.isStore = 1'b0;
		endcase

		// Store sizes follow the opcode suffix as for loads
		if (instr.opcode == OP_STB)
			op.size = SzByte;
		else if (instr.opcode == OP_STW)
			op.size = SzWyde;
		else if (instr.opcode == OP_STT)
			op.size = SzTetra;

		// The X forms take base plus index instead of a displacement
		op.indexed = (instr.opcode == OP_LDX) || (instr.opcode == OP_STX);
	end

	// Any load or store goes down the memory pipe
	assign isMem = op.isLoad | op.isStore;

endmodule

// ==== hdl/QuplsLoadAlign.sv ====
// Result stage aligning, masking and extending load data and raising the completion strobes
`timescale 1ns/1ps

module QuplsLoadAlign import QuplsMemPkg::*;
(
	input logic clk,
	input logic arstN,
	input memReq_t ramReq,
	input logic [DataWidth-1:0] ramData,
	output memResult_t result,
	output logic storeDone,
	output logic alignFault
);

	logic [DataWidth-1:0] shifted;
	logic [DataWidth-1:0] extended;
	logic loadOk;
	logic storeOk;
	logic faultHit;
	logic resValidQ;
	logic [TagWidth-1:0] resTagQ;
	logic [DataWidth-1:0] resDataQ;

	// ==========================================================================
	// Lane shift and extension
	// ==========================================================================

	always_comb
	begin
		// The addressed byte moves down to bit zero
		shifted = ramData >> {ramReq.byteLane, 3'b000};
		case (ramReq.size)
			SzByte:
				extended = {{(DataWidth-8){ramReq.signExt & shifted[7]}}, shifted[7:0]};
			SzWyde:
				extended = {{(DataWidth-16){ramReq.signExt & shifted[15]}}, shifted[15:0]};
			SzTetra:
				extended = {{(DataWidth-32){ramReq.signExt & shifted[31]}}, shifted[31:0]};
			default:
				extended = shifted;
		endcase
	end

	// Exactly one strobe fires per valid request
	assign loadOk = ramReq.valid & ramReq.isLoad & ~ramReq.fault;
	assign storeOk = ramReq.valid & ramReq.isStore & ~ramReq.fault;
	assign faultHit = ramReq.valid & ramReq.fault;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			resValidQ <= 1'b0;
			storeDone <= 1'b0;
			alignFault <= 1'b0;
		end
		else
		begin
			resValidQ <= loadOk;
			storeDone <= storeOk;
			alignFault <= faultHit;
		end
	end

	// Tag and data hold their last load value between results
	always_ff @(posedge clk)
	begin
		if (loadOk)
		begin
			resTagQ <= ramReq.tag;
			resDataQ <= extended;
		end
	end

	assign result = '{valid: resValidQ, tag: resTagQ, data: resDataQ};

endmodule

// ==== hdl/QuplsMemPkg.sv ====
// Shared widths, opcode and size encodings and stage records for the memory-access slice
package QuplsMemPkg;

	// ==========================================================================
	// Widths
	// ==========================================================================

	// Register and bus data width of the core
	localparam int DataWidth = 64;
	// Effective addresses are formed at this width and then truncated
	localparam int AddrWidth = 32;
	// The data memory holds this many octas
	localparam int RamDepth = 256;
	// Octa index into the data memory, taken from address bits 10 to 3
	localparam int RamAddrWidth = 8;
	// Register number width
	localparam int TagWidth = 5;
	// Byte lanes within one octa
	localparam int BytesPerWord = DataWidth / 8;
	// Bits needed to select a byte lane
	localparam int LaneWidth = 3;
	// Signed displacement carried in the instruction word
	localparam int DispWidth = 15;

	// ==========================================================================
	// Encodings
	// ==========================================================================

	// Memory opcodes; any code not listed here is a non-memory operation
	typedef enum logic [6:0]
	{
		OP_LDB  = 7'h40,
		OP_LDBU = 7'h41,
		OP_LDW  = 7'h42,
		OP_LDWU = 7'h43,
		OP_LDT  = 7'h44,
		OP_LDTU = 7'h45,
		OP_LDO  = 7'h46,
		OP_LDX  = 7'h47,
		OP_STB  = 7'h50,
		OP_STW  = 7'h51,
		OP_STT  = 7'h52,
		OP_STO  = 7'h53,
		OP_STX  = 7'h54
	} opcode_e;

	// Access sizes of one, two, four and eight bytes
	typedef enum logic [1:0]
	{
		SzByte  = 2'd0,
		SzWyde  = 2'd1,
		SzTetra = 2'd2,
		SzOcta  = 2'd3
	} memSize_e;

	// ==========================================================================
	// Records
	// ==========================================================================

	// Instruction word; for indexed ops rb sits in the low five bits of disp
	typedef struct packed
	{
		logic [DispWidth-1:0] disp;
		logic [TagWidth-1:0] ra;
		logic [TagWidth-1:0] rt;
		opcode_e opcode;
	} instruction_t;

	// Decoded memory operation
	typedef struct packed
	{
		logic isLoad;
		logic isStore;
		memSize_e size;
		logic signExt;
		logic indexed;
		logic [TagWidth-1:0] tag;
	} memOp_t;

	// Request handed from execute to memory and from memory to result
	typedef struct packed
	{
		logic valid;
		logic isLoad;
		logic isStore;
		logic fault;
		logic [RamAddrWidth-1:0] wordAddr;
		logic [LaneWidth-1:0] byteLane;
		logic [BytesPerWord-1:0] byteEn;
		logic [DataWidth-1:0] wrData;
		memSize_e size;
		logic signExt;
		logic [TagWidth-1:0] tag;
	} memReq_t;

	// Load result tagged with its target register
	typedef struct packed
	{
		logic valid;
		logic [TagWidth-1:0] tag;
		logic [DataWidth-1:0] data;
	} memResult_t;

endpackage

// ==== hdl/QuplsMemUnit.sv ====
// Memory-access unit joining decode, execute, data memory and result alignment
`timescale 1ns/1ps

module QuplsMemUnit import QuplsMemPkg::*;
(
	input logic clk,
	input logic arstN,
	input logic instrValid,
	input instruction_t instr,
	input logic [DataWidth-1:0] aVal,
	input logic [DataWidth-1:0] bVal,
	input logic [DataWidth-1:0] tVal,
	output memResult_t result,
	output logic storeDone,
	output logic alignFault
);

	// ==========================================================================
	// Stage wiring
	// ==========================================================================

	memOp_t decOp;
	logic decIsMem;
	// Execute output, one edge after issue
	memReq_t agenReq;
	// Memory output, two edges after issue
	memReq_t ramReq;
	logic [DataWidth-1:0] ramData;

	// Combinational classification of the incoming word
	QuplsDecodeMem i_QuplsDecodeMem
	(
		.instr(instr),
		.op(decOp),
		.isMem(decIsMem)
	);

	QuplsAgen i_QuplsAgen
	(
		.clk(clk),
		.arstN(arstN),
		.instrValid(instrValid),
		.isMem(decIsMem),
		.op(decOp),
		.instr(instr),
		.aVal(aVal),
		.bVal(bVal),
		.tVal(tVal),
		.agenReq(agenReq)
	);

	QuplsDataRam i_QuplsDataRam
	(
		.clk(clk),
		.arstN(arstN),
		.agenReq(agenReq),
		.ramReq(ramReq),
		.ramData(ramData)
	);

	// Completion strobes come out three edges after issue
	QuplsLoadAlign i_QuplsLoadAlign
	(
		.clk(clk),
		.arstN(arstN),
		.ramReq(ramReq),
		.ramData(ramData),
		.result(result),
		.storeDone(storeDone),
		.alignFault(alignFault)
	);

endmodule

// ==== testbench/QuplsMemUnitTb.sv ====
// Directed testbench for the memory-access unit with a byte-level reference memory
`timescale 1ns/1ps

module QuplsMemUnitTb import QuplsMemPkg::*;
();

	// Kinds of completion the unit can report
	typedef enum logic [1:0] {DoneLoad, DoneStore, DoneFault} doneKind_e;

	typedef struct packed
	{
		doneKind_e kind;
		logic [TagWidth-1:0] tag;
		logic [DataWidth-1:0] data;
		logic [31:0] due;
	} expect_t;

	logic clk;
	logic arstN;
	logic instrValid;
	instruction_t instr;
	logic [DataWidth-1:0] aVal;
	logic [DataWidth-1:0] bVal;
	logic [DataWidth-1:0] tVal;
	memResult_t result;
	logic storeDone;
	logic alignFault;

	// Reference memory covers the 2 KiB the unit can address before it wraps
	logic [7:0] refMem [2048];
	expect_t expQ[$];
	int negCount = 0;
	int checkCount = 0;
	int errorCount = 0;

	QuplsMemUnit i_QuplsMemUnit
	(
		.clk(clk),
		.arstN(arstN),
		.instrValid(instrValid),
		.instr(instr),
		.aVal(aVal),
		.bVal(bVal),
		.tVal(tVal),
		.result(result),
		.storeDone(storeDone),
		.alignFault(alignFault)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ==========================================================================
	// Reference rules
	// ==========================================================================

	// Access width in bytes, zero for a non-memory opcode
	function automatic int accessBytes(input logic [6:0] opc);
		case (opc)
			OP_LDB, OP_LDBU, OP_STB: return 1;
			OP_LDW, OP_LDWU, OP_STW: return 2;
			OP_LDT, OP_LDTU, OP_STT: return 4;
			OP_LDO, OP_LDX, OP_STO, OP_STX: return 8;
			default: return 0;
		endcase
	endfunction

	function automatic logic [31:0] dispOffset(input logic [DispWidth-1:0] d);
		return {{(32-DispWidth){d[DispWidth-1]}}, d};
	endfunction

	// Base value that lands on target once the offset is added
	function automatic logic [63:0] baseFor(input logic [31:0] target,
		input logic [31:0] offset);
		return {$urandom(), target - offset};
	endfunction

	task automatic checkValue(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		checkCount++;
		if (actual !== expected)
		begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			errorCount++;
		end
	endtask

	// Drives one op for a cycle and records what it must produce
	task automatic issueOp(input logic [6:0] opc, input logic [TagWidth-1:0] rt,
		input logic [DispWidth-1:0] dispField, input logic [63:0] a, input logic [63:0] b,
		input logic [63:0] t);
		instruction_t w;
		int n;
		logic [31:0] addr;
		logic [63:0] val;
		expect_t e;
		n = accessBytes(opc);
		w.opcode = opcode_e'(opc);
		w.rt = rt;
		w.ra = 5'($urandom());
		w.disp = dispField;
		@(posedge clk);
		instrValid <= 1'b1;
		instr <= w;
		aVal <= a;
		bVal <= b;
		tVal <= t;
		if (n == 0)
			return;
		addr = a[31:0] + ((opc == OP_LDX || opc == OP_STX) ? b[31:0] : dispOffset(dispField));
		// Completion shows after the sampling, memory and result edges
		e.due = negCount + 4;
		e.tag = rt;
		e.data = '0;
		if (addr % n != 0)
			e.kind = DoneFault;
		else if (opc >= OP_STB)
		begin
			e.kind = DoneStore;
			for (int i = 0; i < n; i++)
				refMem[addr[10:0] + 11'(i)] = t[i*8 +: 8];
		end
		else
		begin
			val = '0;
			for (int i = 0; i < n; i++)
				val[i*8 +: 8] = refMem[addr[10:0] + 11'(i)];
			if ((opc == OP_LDB || opc == OP_LDW || opc == OP_LDT) && val[n*8-1])
				for (int i = n; i < 8; i++)
					val[i*8 +: 8] = 8'hFF;
			e.kind = DoneLoad;
			e.data = val;
		end
		expQ.push_back(e);
	endtask

	// Stops issuing and lets the pipe empty out
	task automatic waitIdle();
		int guard;
		guard = 0;
		@(posedge clk);
		instrValid <= 1'b0;
		while (expQ.size() != 0 && guard < 40)
		begin
			@(posedge clk);
			guard++;
		end
		if (expQ.size() != 0)
		begin
			$display("Timed out with %0d completions still outstanding", expQ.size());
			errorCount++;
			expQ.delete();
		end
	endtask

	// Every strobe is matched in order against the head of the queue
	always @(negedge clk)
	begin
		expect_t head;
		logic anyPulse;
		negCount++;
		anyPulse = (result.valid === 1'b1) || (storeDone === 1'b1) || (alignFault === 1'b1);
		if (expQ.size() == 0)
		begin
			if (anyPulse)
			begin
				$display("Unexpected completion at %0t ns with nothing outstanding", $time);
				errorCount++;
			end
		end
		else if (anyPulse || expQ[0].due <= negCount)
		begin
			head = expQ.pop_front();
			checkValue("completion edge", negCount, head.due);
			checkValue("result.valid", result.valid, head.kind == DoneLoad);
			checkValue("storeDone", storeDone, head.kind == DoneStore);
			checkValue("alignFault", alignFault, head.kind == DoneFault);
			if (head.kind == DoneLoad)
			begin
				checkValue("result.tag", result.tag, head.tag);
				checkValue("result.data", result.data, head.data);
			end
		end
	end

	// ==========================================================================
	// Tests
	// ==========================================================================

	task automatic testReset();
		// Strobes must stay low on every falling edge while reset is held
		for (int i = 0; i < 4; i++)
		begin
			@(negedge clk);
			checkValue("result.valid", result.valid, 0);
			checkValue("storeDone", storeDone, 0);
			checkValue("alignFault", alignFault, 0);
		end
		@(posedge clk);
		arstN <= 1'b1;
		// The monitor flags any strobe in the quiet edges after release
		repeat (4) @(posedge clk);
		$display("Test reset finished, %0d errors so far", errorCount);
	endtask

	// Every octa gets known contents so later loads never read undefined bytes
	task automatic fillMemory();
		logic [63:0] a;
		for (int w = 0; w < RamDepth; w++)
		begin
			a = {$urandom(), $urandom()};
			a[10:0] = {8'(w), 3'b000};
			issueOp(OP_STO, 5'($urandom()), '0, a, '0, {$urandom(), $urandom()});
		end
		waitIdle();
	endtask

	task automatic testSizes();
		opcode_e stOps[4] = '{OP_STB, OP_STW, OP_STT, OP_STO};
		opcode_e ldOps[4] = '{OP_LDB, OP_LDW, OP_LDT, OP_LDO};
		opcode_e luOps[4] = '{OP_LDBU, OP_LDWU, OP_LDTU, OP_LDO};
		logic [31:0] target;
		logic [DispWidth-1:0] d;
		for (int s = 0; s < 4; s++)
		begin
			for (int lane = 0; lane < 8; lane += accessBytes(stOps[s]))
			begin
				target = {21'($urandom()), 8'($urandom()), 3'(lane)};
				d = 15'($urandom());
				issueOp(stOps[s], 5'($urandom()), d, baseFor(target, dispOffset(d)), '0,
					{$urandom(), $urandom()});
				issueOp(ldOps[s], 5'($urandom()), d, baseFor(target, dispOffset(d)), '0, '0);
				issueOp(luOps[s], 5'($urandom()), d, baseFor(target, dispOffset(d)), '0, '0);
			end
			waitIdle();
		end
		$display("Test sizes finished, %0d errors so far", errorCount);
	endtask

	task automatic testIndexed();
		logic [31:0] target;
		logic [63:0] b;
		for (int i = 0; i < 16; i++)
		begin
			// Full 32-bit targets put most sums far above 2 KiB
			target = {$urandom()} & ~32'h7;
			b = {$urandom(), $urandom()};
			issueOp(OP_STX, 5'($urandom()), 15'($urandom()), baseFor(target, b[31:0]), b,
				{$urandom(), $urandom()});
			b = {$urandom(), $urandom()};
			issueOp(OP_LDX, 5'($urandom()), 15'($urandom()), baseFor(target, b[31:0]), b, '0);
		end
		waitIdle();
		$display("Test indexed finished, %0d errors so far", errorCount);
	endtask

	task automatic testNonMemAndFaults();
		opcode_e stOps[3] = '{OP_STW, OP_STT, OP_STO};
		opcode_e ldOps[3] = '{OP_LDW, OP_LDT, OP_LDO};
		logic [31:0] target;
		int lane;
		issueOp(7'h00, 5'd3, 15'($urandom()), {$urandom(), $urandom()}, '0, '0);
		issueOp(7'h33, 5'd4, 15'($urandom()), {$urandom(), $urandom()}, '0, '0);
		// A quiet window in which the monitor must see no strobe at all
		@(posedge clk);
		instrValid <= 1'b0;
		repeat (10) @(posedge clk);
		for (int s = 0; s < 3; s++)
		begin
			lane = 1 + ($urandom() % 7);
			while (lane % accessBytes(stOps[s]) == 0)
				lane = 1 + ($urandom() % 7);
			target = {21'($urandom()), 8'($urandom()), 3'(lane)};
			issueOp(stOps[s], 5'($urandom()), '0, baseFor(target, 0), '0,
				{$urandom(), $urandom()});
			issueOp(ldOps[s], 5'($urandom()), '0, baseFor(target, 0), '0, '0);
			// The enclosing octa must still hold its old bytes
			issueOp(OP_LDO, 5'($urandom()), '0, baseFor(target & ~32'h7, 0), '0, '0);
		end
		waitIdle();
		$display("Test non-memory and misaligned finished, %0d errors so far", errorCount);
	endtask

	task automatic testTraffic();
		opcode_e ops[13] = '{OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO,
			OP_LDX, OP_STB, OP_STW, OP_STT, OP_STO, OP_STX};
		opcode_e opc;
		int n;
		logic [31:0] target;
		logic [63:0] b;
		logic [DispWidth-1:0] d;
		for (int i = 0; i < 200; i++)
		begin
			opc = ops[$urandom() % 13];
			n = accessBytes(opc);
			// Eight octas keep stores and loads colliding often
			target = {21'($urandom()), 8'($urandom() % 8), 3'(($urandom() % (8 / n)) * n)};
			b = {$urandom(), $urandom()};
			d = 15'($urandom());
			issueOp(opc, 5'($urandom()), d,
				baseFor(target, (opc == OP_LDX || opc == OP_STX) ? b[31:0] : dispOffset(d)), b,
				{$urandom(), $urandom()});
		end
		waitIdle();
		$display("Test back-to-back traffic finished, %0d errors so far", errorCount);
	endtask

	initial
	begin
		void'($urandom(66));
		arstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		aVal = '0;
		bVal = '0;
		tVal = '0;
		testReset();
		fillMemory();
		testSizes();
		testIndexed();
		testNonMemAndFaults();
		testTraffic();
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule
